// ==== decode_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, enums and structs for the
// RV32I decode stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package decode_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  // The one SYSTEM encoding still accepted
  localparam word_t HALT_INSTR = 32'h0000_0073;

  // Major opcodes of the kept instruction classes
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_t;

  // Operand and write-back selectors
  typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} a_sel_t;
  typedef enum logic [1:0] {B_RS2, B_IMM_I, B_IMM_S, B_IMM_U} b_sel_t;
  typedef enum logic [1:0] {W_ALU, W_PC4, W_IMM_U, W_LOAD} w_sel_t;

  typedef struct packed {
    logic  valid;
    word_t instr;
    word_t pc;
    word_t pc4;
  } fetch_decode_t;

  typedef struct packed {
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;
  } imm_t;

  typedef struct packed {
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    alu_op_t    alu_op;
    a_sel_t     a_sel;
    b_sel_t     b_sel;
    w_sel_t     w_sel;
    logic       wen;
    logic       dren;
    logic       dwen;
    logic [2:0] load_type;
    logic       branch;
    logic [2:0] branch_type;
    logic       jump;
    // Set for JAL, clear for JALR
    logic       j_sel;
    logic       halt;
    logic       illegal;
  } ctrl_t;

  typedef struct packed {
    logic      wen;
    reg_addr_t rd;
    word_t     wdata;
  } rf_write_t;

  typedef struct packed {
    logic  valid;
    ctrl_t ctrl;
    word_t pc;
    word_t pc4;
    word_t rs1_data;
    word_t rs2_data;
    word_t port_a;
    word_t port_b;
    word_t reg_file_wdata;
    word_t j_base;
    word_t j_offset;
    word_t br_imm;
  } id_ex_t;

endpackage

// ==== decode_control.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Opcode and funct decoder for RV32I
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module decode_control import decode_pkg::*; (
  input  word_t instr,
  output ctrl_t ctrl
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       bit30;
  alu_op_t    funct_op;

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign bit30  = instr[30];

  // ALU operation from funct3, common to OP and OP-IMM
  always_comb begin
    case (funct3)
      3'b000:  funct_op = ALU_ADD;
      3'b001:  funct_op = ALU_SLL;
      3'b010:  funct_op = ALU_SLT;
      3'b011:  funct_op = ALU_SLTU;
      3'b100:  funct_op = ALU_XOR;
      3'b101:  funct_op = bit30 ? ALU_SRA : ALU_SRL;
      3'b110:  funct_op = ALU_OR;
      default: funct_op = ALU_AND;
    endcase
  end

  always_comb begin
    ctrl             = '0;
    ctrl.rs1         = instr[19:15];
    ctrl.rs2         = instr[24:20];
    ctrl.rd          = instr[11:7];
    ctrl.alu_op      = ALU_ADD;
    ctrl.a_sel       = A_RS1;
    ctrl.b_sel       = B_RS2;
    ctrl.w_sel       = W_ALU;
    ctrl.load_type   = funct3;
    ctrl.branch_type = funct3;
    ctrl.wen         = 1'b1;

    case (opcode)
      OP: begin
        // Bit 30 only turns ADD into SUB here; SRA is already in funct_op
        ctrl.alu_op = (funct3 == 3'b000 && bit30) ? ALU_SUB : funct_op;
      end
      OP_IMM: begin
        ctrl.b_sel  = B_IMM_I;
        ctrl.alu_op = funct_op;
      end
      LUI: begin
        ctrl.a_sel = A_ZERO;
        ctrl.b_sel = B_IMM_U;
        ctrl.w_sel = W_IMM_U;
      end
      AUIPC: begin
        ctrl.a_sel = A_PC;
        ctrl.b_sel = B_IMM_U;
      end
      JAL: begin
        ctrl.jump  = 1'b1;
        ctrl.j_sel = 1'b1;
        ctrl.w_sel = W_PC4;
      end
      JALR: begin
        ctrl.jump  = 1'b1;
        ctrl.w_sel = W_PC4;
      end
      BRANCH: begin
        ctrl.branch = 1'b1;
        ctrl.wen    = 1'b0;
      end
      LOAD: begin
        ctrl.b_sel = B_IMM_I;
        ctrl.w_sel = W_LOAD;
        ctrl.dren  = 1'b1;
      end
      STORE: begin
        ctrl.b_sel = B_IMM_S;
        ctrl.dwen  = 1'b1;
        ctrl.wen   = 1'b0;
      end
      SYSTEM: begin
        // Only the halt word survives, the rest of SYSTEM is illegal
        ctrl.wen = 1'b0;
        if (instr == HALT_INSTR) begin
          ctrl.halt = 1'b1;
        end else begin
          ctrl.illegal = 1'b1;
        end
      end
      default: begin
        ctrl.illegal = 1'b1;
        ctrl.wen     = 1'b0;
      end
    endcase

    // Writes to x0 are dropped at decode
    if (ctrl.rd == '0) begin
      ctrl.wen = 1'b0;
    end
  end

endmodule

// ==== imm_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I, S, B, U and J immediate generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module imm_gen import decode_pkg::*; (
  input  word_t instr,
  output imm_t  imm
);

  logic sign;

  assign sign = instr[31];

  assign imm.imm_i = {{20{sign}}, instr[31:20]};
  assign imm.imm_s = {{20{sign}}, instr[31:25], instr[11:7]};

  // Branch offset with bit 0 always zero
  assign imm.imm_b = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};

  // Upper immediate already shifted into place
  assign imm.imm_u = {instr[31:12], 12'b0};

  assign imm.imm_j = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};

endmodule

// ==== operand_select.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU operand, write-back and jump operand
// selection
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module operand_select import decode_pkg::*; (
  input  ctrl_t ctrl,
  input  imm_t  imm,
  input  word_t rs1_data,
  input  word_t rs2_data,
  input  word_t pc,
  input  word_t pc4,
  output word_t port_a,
  output word_t port_b,
  output word_t reg_file_wdata,
  output word_t j_base,
  output word_t j_offset
);

  logic  is_shift;
  word_t imm_or_shamt;

  // Immediate shifts only use the low 5 bits as shamt
  assign is_shift     = ctrl.alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA};
  assign imm_or_shamt = is_shift ? {{(XLEN-5){1'b0}}, imm.imm_i[4:0]} : imm.imm_i;

  always_comb begin
    case (ctrl.a_sel)
      A_RS1:   port_a = rs1_data;
      A_PC:    port_a = pc;
      default: port_a = '0;
    endcase
  end

  always_comb begin
    case (ctrl.b_sel)
      B_RS2:   port_b = rs2_data;
      B_IMM_I: port_b = imm_or_shamt;
      B_IMM_S: port_b = imm.imm_s;
      default: port_b = imm.imm_u;
    endcase
  end

  // Early write-back value; ALU and load results come later
  always_comb begin
    case (ctrl.w_sel)
      W_PC4:   reg_file_wdata = pc4;
      W_IMM_U: reg_file_wdata = imm.imm_u;
      default: reg_file_wdata = '0;
    endcase
  end

  // JAL is PC relative, JALR is register relative
  assign j_base   = ctrl.j_sel ? pc : rs1_data;
  assign j_offset = ctrl.j_sel ? imm.imm_j : imm.imm_i;

endmodule

// ==== reg_file.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer register file, 2 read / 1 write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module reg_file import decode_pkg::*; #(
  parameter int NUM_REGS = 32
) (
  input  logic      CLK,
  input  logic      nRST,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  rf_write_t wr,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [NUM_REGS];

  // x0 and indices past the end of a reduced file read zero and ignore writes
  function automatic logic in_range(reg_addr_t addr);
    return (addr != '0) && (int'(addr) < NUM_REGS);
  endfunction

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs <= '{default: '0};
    end else if (wr.wen && in_range(wr.rd)) begin
      regs[wr.rd] <= wr.wdata;
    end
  end

  // A same-cycle write shows up only after the edge
  assign rs1_data = in_range(rs1) ? regs[rs1] : '0;
  assign rs2_data = in_range(rs2) ? regs[rs2] : '0;

endmodule

// ==== id_ex_register.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ID/EX pipeline register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module id_ex_register import decode_pkg::*; (
  input  logic   CLK,
  input  logic   nRST,
  input  logic   stall,
  input  logic   flush,
  input  id_ex_t next,
  output id_ex_t id_ex
);

  id_ex_t stage_q;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      stage_q <= '0;
    end else if (flush) begin
      // Bubble with every enable and the valid flag low
      stage_q <= '0;
    end else if (!stall) begin
      stage_q <= next;
    end
  end

  assign id_ex = stage_q;

endmodule

// ==== decode_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I decode stage top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; #(
  parameter int NUM_REGS = 32
) (
  input  logic          CLK,
  input  logic          nRST,
  input  logic          stall,
  input  logic          flush,
  input  fetch_decode_t in,
  input  rf_write_t     rf_wr,
  output id_ex_t        id_ex
);

  ctrl_t  ctrl;
  imm_t   imm;
  word_t  rs1_data, rs2_data;
  word_t  port_a, port_b, reg_file_wdata;
  word_t  j_base, j_offset;
  id_ex_t next_id_ex;

  decode_control u_control (
    .instr (in.instr),
    .ctrl  (ctrl)
  );

  imm_gen u_imm_gen (
    .instr (in.instr),
    .imm   (imm)
  );

  reg_file #(.NUM_REGS(NUM_REGS)) u_reg_file (
    .CLK      (CLK),
    .nRST     (nRST),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .wr       (rf_wr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  operand_select u_operand_select (
    .ctrl           (ctrl),
    .imm            (imm),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .pc             (in.pc),
    .pc4            (in.pc4),
    .port_a         (port_a),
    .port_b         (port_b),
    .reg_file_wdata (reg_file_wdata),
    .j_base         (j_base),
    .j_offset       (j_offset)
  );

  // Next ID/EX contents
  always_comb begin
    next_id_ex.valid          = in.valid;
    next_id_ex.ctrl           = ctrl;
    next_id_ex.pc             = in.pc;
    next_id_ex.pc4            = in.pc4;
    next_id_ex.rs1_data       = rs1_data;
    next_id_ex.rs2_data       = rs2_data;
    next_id_ex.port_a         = port_a;
    next_id_ex.port_b         = port_b;
    next_id_ex.reg_file_wdata = reg_file_wdata;
    next_id_ex.j_base         = j_base;
    next_id_ex.j_offset       = j_offset;
    next_id_ex.br_imm         = imm.imm_b;
  end

  id_ex_register u_id_ex (
    .CLK   (CLK),
    .nRST  (nRST),
    .stall (stall),
    .flush (flush),
    .next  (next_id_ex),
    .id_ex (id_ex)
  );

endmodule

// ==== tb_clock_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 4
) (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  // Release lands in the stimulus phase, just after a rising edge
  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #(PERIOD / 10);
    nRST = 1'b1;
  end

endmodule

// ==== decode_stage_properties.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Assertions on the ID/EX pipeline register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module decode_stage_properties import decode_pkg::*; (
  input logic   CLK,
  input logic   nRST,
  input logic   stall,
  input logic   flush,
  input id_ex_t id_ex
);

  int failures = 0;

  // Bubble one cycle after flush
  flush_bubble: assert property (@(posedge CLK) disable iff (!nRST)
    flush |=> !id_ex.valid)
    else begin
      $error("flush did not clear id_ex.valid");
      failures++;
    end

  stall_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (stall && !flush) |=> $stable(id_ex))
    else begin
      $error("id_ex changed during stall");
      failures++;
    end

  // An illegal instruction must not touch registers or memory
  illegal_quiet: assert property (@(posedge CLK) disable iff (!nRST)
    id_ex.ctrl.illegal |-> !(id_ex.ctrl.wen || id_ex.ctrl.dren || id_ex.ctrl.dwen))
    else begin
      $error("illegal instruction with an enable set");
      failures++;
    end

endmodule

bind id_ex_register decode_stage_properties u_properties (
  .CLK   (CLK),
  .nRST  (nRST),
  .stall (stall),
  .flush (flush),
  .id_ex (id_ex)
);

// ==== decode_stage_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests, compare tasks, watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module decode_stage_tb import decode_pkg::*; ();

  localparam int NUM_TESTS   = 6;
  localparam int TEST_CYCLES = 40;
  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;

  logic          CLK;
  logic          nRST;
  logic          stall;
  logic          flush;
  fetch_decode_t in;
  rf_write_t     rf_wr;
  id_ex_t        id_ex;

  int    seed   = 32'h776f9643;
  int    errors = 0;
  int    checks = 0;
  // Expected register contents with x0 held at zero
  word_t rf_model [32] = '{default: '0};

  tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(4)) u_clock_gen (
    .CLK  (CLK),
    .nRST (nRST)
  );

  decode_stage #(.NUM_REGS(32)) UUT (
    .CLK   (CLK),
    .nRST  (nRST),
    .stall (stall),
    .flush (flush),
    .in    (in),
    .rf_wr (rf_wr),
    .id_ex (id_ex)
  );

  task automatic check_word(string name, word_t exp, word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_alu_op(string name, alu_op_t exp, alu_op_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %s, actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_sel(string name, b_sel_t exp, b_sel_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %s, actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_reg_addr(string name, reg_addr_t exp, reg_addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected x%0d, actual x%0d", name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // Instruction encoders, one per RV32I format
  function automatic word_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3, reg_addr_t rd, opcode_t op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic word_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                   reg_addr_t rd, opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
  endfunction

  function automatic word_t b_type(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
  endfunction

  function automatic word_t u_type(logic [19:0] imm, reg_addr_t rd, opcode_t op);
    return {imm, rd, op};
  endfunction

  function automatic word_t j_type(logic [20:0] imm, reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
  endfunction

  task automatic next_cycle();
    @(posedge CLK);
    #(DRIVE_DELAY);
  endtask

  task automatic write_reg(reg_addr_t rd, word_t data);
    rf_wr = '{wen: 1'b1, rd: rd, wdata: data};
    next_cycle();
    rf_wr.wen = 1'b0;
    if (rd != '0) begin
      rf_model[rd] = data;
    end
  endtask

  task automatic fill_regs();
    for (int i = 1; i < 8; i++) begin
      write_reg(reg_addr_t'(i), $random(seed));
    end
  endtask

  // Present one instruction and let it reach id_ex
  task automatic issue(word_t instr, word_t pc);
    in = '{valid: 1'b1, instr: instr, pc: pc, pc4: pc + 32'd4};
    next_cycle();
  endtask

  task automatic expect_alu(string name, word_t a, word_t b, alu_op_t op,
                            reg_addr_t rd, logic wen);
    check_word({name, " port_a"}, a, id_ex.port_a);
    check_word({name, " port_b"}, b, id_ex.port_b);
    check_alu_op({name, " alu_op"}, op, id_ex.ctrl.alu_op);
    check_reg_addr({name, " rd"}, rd, id_ex.ctrl.rd);
    check_bit({name, " wen"}, wen, id_ex.ctrl.wen);
  endtask

  task automatic reset_values();
    check_bit("reset valid", 1'b0, id_ex.valid);
    check_bit("reset wen", 1'b0, id_ex.ctrl.wen);
    check_bit("reset dren", 1'b0, id_ex.ctrl.dren);
    check_bit("reset dwen", 1'b0, id_ex.ctrl.dwen);
    check_bit("reset jump", 1'b0, id_ex.ctrl.jump);
    check_bit("reset halt", 1'b0, id_ex.ctrl.halt);
  endtask

  task automatic alu_ops();
    fill_regs();
    issue(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd5, OP), 32'h40);
    expect_alu("add", rf_model[1], rf_model[2], ALU_ADD, 5'd5, 1'b1);
    issue(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd6, OP), 32'h44);
    expect_alu("sub", rf_model[1], rf_model[2], ALU_SUB, 5'd6, 1'b1);
    issue(r_type(7'h20, 5'd3, 5'd1, 3'b101, 5'd7, OP), 32'h48);
    expect_alu("sra", rf_model[1], rf_model[3], ALU_SRA, 5'd7, 1'b1);
    issue(i_type(12'hFFB, 5'd3, 3'b000, 5'd8, OP_IMM), 32'h4C);
    expect_alu("addi", rf_model[3], 32'hFFFF_FFFB, ALU_ADD, 5'd8, 1'b1);
    check_sel("addi b_sel", B_IMM_I, id_ex.ctrl.b_sel);
    // Destination x0 must not write back
    issue(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd0, OP), 32'h50);
    expect_alu("add x0", rf_model[1], rf_model[2], ALU_ADD, 5'd0, 1'b0);
  endtask

  task automatic upper_and_jump();
    fill_regs();
    issue(u_type(20'hABCDE, 5'd9, LUI), 32'h100);
    check_word("lui wdata", 32'hABCD_E000, id_ex.reg_file_wdata);
    issue(u_type(20'h12345, 5'd10, AUIPC), 32'h104);
    check_word("auipc port_a", 32'h104, id_ex.port_a);
    check_word("auipc port_b", 32'h1234_5000, id_ex.port_b);
    issue(j_type(21'h1F_EDCC, 5'd1), 32'h200);
    check_bit("jal jump", 1'b1, id_ex.ctrl.jump);
    check_word("jal j_base", 32'h200, id_ex.j_base);
    check_word("jal j_offset", 32'hFFFF_EDCC, id_ex.j_offset);
    check_word("jal wdata", 32'h204, id_ex.reg_file_wdata);
    check_word("jal pc4", 32'h204, id_ex.pc4);
    issue(i_type(12'h010, 5'd4, 3'b000, 5'd1, JALR), 32'h300);
    check_bit("jalr jump", 1'b1, id_ex.ctrl.jump);
    check_word("jalr j_base", rf_model[4], id_ex.j_base);
    check_word("jalr j_offset", 32'h10, id_ex.j_offset);
    check_word("jalr wdata", 32'h304, id_ex.reg_file_wdata);
  endtask

  task automatic mem_and_branch();
    fill_regs();
    issue(i_type(12'hFF4, 5'd2, 3'b010, 5'd11, LOAD), 32'h400);
    check_word("load port_a", rf_model[2], id_ex.port_a);
    check_word("load port_b", 32'hFFFF_FFF4, id_ex.port_b);
    check_word("load type", 32'd2, word_t'(id_ex.ctrl.load_type));
    check_bit("load dren", 1'b1, id_ex.ctrl.dren);
    issue(s_type(12'hDA4, 5'd3, 5'd5, 3'b010), 32'h404);
    check_sel("store b_sel", B_IMM_S, id_ex.ctrl.b_sel);
    check_word("store port_b", 32'hFFFF_FDA4, id_ex.port_b);
    check_bit("store dwen", 1'b1, id_ex.ctrl.dwen);
    check_bit("store wen", 1'b0, id_ex.ctrl.wen);
    issue(b_type(13'h1FF0, 5'd7, 5'd6, 3'b001), 32'h408);
    check_word("branch br_imm", 32'hFFFF_FFF0, id_ex.br_imm);
    check_word("branch type", 32'd1, word_t'(id_ex.ctrl.branch_type));
    check_reg_addr("branch rs1", 5'd6, id_ex.ctrl.rs1);
    check_reg_addr("branch rs2", 5'd7, id_ex.ctrl.rs2);
    check_word("branch port_a", rf_model[6], id_ex.port_a);
    check_word("branch port_b", rf_model[7], id_ex.port_b);
    check_bit("branch flag", 1'b1, id_ex.ctrl.branch);
    check_bit("branch wen", 1'b0, id_ex.ctrl.wen);
  endtask

  task automatic pipeline_control();
    fill_regs();
    issue(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd5, OP), 32'h500);
    stall = 1'b1;
    issue(r_type(7'h20, 5'd4, 5'd3, 3'b000, 5'd6, OP), 32'h504);
    next_cycle();
    check_word("stall pc", 32'h500, id_ex.pc);
    expect_alu("stall hold", rf_model[1], rf_model[2], ALU_ADD, 5'd5, 1'b1);
    stall = 1'b0;
    next_cycle();
    expect_alu("stall release", rf_model[3], rf_model[4], ALU_SUB, 5'd6, 1'b1);
    flush = 1'b1;
    next_cycle();
    check_bit("flush valid", 1'b0, id_ex.valid);
    check_bit("flush wen", 1'b0, id_ex.ctrl.wen);
    check_word("flush port_a", 32'h0, id_ex.port_a);
    flush = 1'b0;
    issue(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd5, OP), 32'h508);
    check_bit("refill valid", 1'b1, id_ex.valid);
    // Flush beats stall
    stall = 1'b1;
    flush = 1'b1;
    next_cycle();
    check_bit("flush over stall valid", 1'b0, id_ex.valid);
    check_word("flush over stall pc", 32'h0, id_ex.pc);
    stall = 1'b0;
    flush = 1'b0;
  endtask

  task automatic corner_cases();
    fill_regs();
    issue(32'h0000_0FFF, 32'h600);
    check_bit("unknown illegal", 1'b1, id_ex.ctrl.illegal);
    check_bit("unknown wen", 1'b0, id_ex.ctrl.wen);
    check_bit("unknown dren", 1'b0, id_ex.ctrl.dren);
    check_bit("unknown dwen", 1'b0, id_ex.ctrl.dwen);
    issue(32'h0000_0073, 32'h604);
    check_bit("halt flag", 1'b1, id_ex.ctrl.halt);
    check_bit("halt illegal", 1'b0, id_ex.ctrl.illegal);
    check_bit("halt wen", 1'b0, id_ex.ctrl.wen);
    write_reg(5'd0, $random(seed));
    issue(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd5, OP), 32'h608);
    check_word("x0 rs1_data", 32'h0, id_ex.rs1_data);
    check_word("x0 rs2_data", 32'h0, id_ex.rs2_data);
    check_word("x0 port_a", 32'h0, id_ex.port_a);
    check_word("x0 port_b", 32'h0, id_ex.port_b);
  endtask

  initial begin
    stall = 1'b0;
    flush = 1'b0;
    in    = '0;
    rf_wr = '0;
    wait (nRST === 1'b1);
    reset_values();
    alu_ops();
    upper_and_jump();
    mem_and_branch();
    pipeline_control();
    corner_cases();
    in = '0;
    errors += UUT.u_id_ex.u_properties.failures;
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog sized from the test budget
  initial begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("Watchdog timeout: the tests did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== files.f ====
decode_pkg.sv
decode_control.sv
imm_gen.sv
operand_select.sv
reg_file.sv
id_ex_register.sv
decode_stage.sv
tb_clock_gen.sv
decode_stage_properties.sv
decode_stage_tb.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - decode_pkg.sv
  - decode_control.sv
  - imm_gen.sv
  - operand_select.sv
  - reg_file.sv
  - id_ex_register.sv
  - decode_stage.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - decode_stage_properties.sv
      - decode_stage_tb.sv
